// File: Makefile
# Verilator build and run of the APB execute subsystem testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module tb_apb_exec_top -f compile.f
	./obj_dir/Vtb_apb_exec_top | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf obj_dir

// File: compile.f
verilog/rv32i_pkg.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/csr_file.sv
verilog/exec_core.sv
verilog/apb_exec_top.sv
sim/apb_exec_top_sva.sv
sim/tb_apb_exec_top.sv

// File: sim/apb_exec_top_sva.sv
////////////////////////////////////////////////////////////
// APB protocol and core invariants, bound into apb_exec_top
// fail_count is read by the testbench at the end of the run
////////////////////////////////////////////////////////////
`default_nettype none

module apb_exec_top_sva
  import rv32i_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       psel_i,
  input logic       penable_i,
  input logic       pwrite_i,
  input logic [7:0] paddr_i,
  input word_t      prdata_i,
  input logic       pready_i,
  input logic       pslverr_i,
  input logic       halted_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // No wait states
  a_pready_high: assert property (@(posedge clk_i) disable iff (!rst_n_i) pready_i)
    else begin
      $error("pready is low");
      fail_count++;
    end

  a_slverr_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pslverr_i |-> (psel_i && penable_i))
    else begin
      $error("pslverr high outside an access phase");
      fail_count++;
    end

  // Halted only clears through reset
  a_halt_sticky: assert property (@(posedge clk_i) $past(rst_n_i) |-> !$fell(halted_i))
    else begin
      $error("halted fell without reset");
      fail_count++;
    end

  a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (psel_i && !pwrite_i && paddr_i == 8'h80) |-> prdata_i == '0)
    else begin
      $error("x0 read data is not zero");
      fail_count++;
    end

endmodule

bind apb_exec_top apb_exec_top_sva u_sva (
  .clk_i(clk_i), .rst_n_i(rst_n_i), .psel_i(psel_i), .penable_i(penable_i),
  .pwrite_i(pwrite_i), .paddr_i(paddr_i), .prdata_i(prdata_o), .pready_i(pready_o),
  .pslverr_i(pslverr_o), .halted_i(halted)
);

`default_nettype wire

// File: sim/tb_apb_exec_top.sv
////////////////////////////////////////////////////////////
// Drives apb_exec_top over APB against a reference model
// Immediate assertions compare results, bound SVA covers APB
// Operands come from a 32-bit LFSR with a fixed seed
// The DUT runs with RESET_PC = 0x1000
////////////////////////////////////////////////////////////
`default_nettype none

module tb_apb_exec_top
  import rv32i_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    TIMEOUT  = 20;
  localparam word_t RESET_PC = 32'h0000_1000;

  logic       clk;
  logic       rst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  logic [7:0] paddr;
  word_t      pwdata;
  word_t      prdata;
  logic       pready;
  logic       pslverr;

  // Reference model state
  word_t m_regs [32];
  word_t m_pc;
  word_t m_mscratch;
  word_t m_minstret;

  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          test_errors;
  string       test_name;

  apb_exec_top #(
    .RESET_PC(RESET_PC)
  ) u_dut (
    .clk_i(clk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
    .pready_o(pready), .pslverr_o(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(rand_bits(5));
  endfunction

  // Instruction encoders
  function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(input word_t imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t u_type(input word_t imm, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm[19:0], rd, op};
  endfunction

  function automatic word_t b_type(input word_t imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic word_t j_type(input word_t imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  function automatic word_t csr_insn(input csr_addr_t addr, input logic [4:0] src,
                                     input logic [2:0] f3, input logic [4:0] rd);
    return {addr, src, f3, rd, SYSTEM};
  endfunction

  function automatic logic signed_lt(input word_t a, input word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, signed_lt(a, b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return signed_lt(a, b);
      3'd5:    return !signed_lt(a, b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Applies one retiring instruction to the model
  function automatic void model_exec(input word_t insn);
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    word_t      a, b, iimm, res, nxt, src;
    f3   = insn[14:12];
    rd   = insn[11:7];
    rs1  = insn[19:15];
    a    = m_regs[rs1];
    b    = m_regs[insn[24:20]];
    iimm = {{20{insn[31]}}, insn[31:20]};
    res  = '0;
    nxt  = m_pc + 32'd4;
    case (insn[6:0])
      LUI:    res = {insn[31:12], 12'b0};
      AUIPC:  res = m_pc + {insn[31:12], 12'b0};
      JAL: begin
        res = nxt;
        nxt = m_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      JALR: begin
        res = nxt;
        nxt = (a + iimm) & ~32'd1;
      end
      BRANCH: begin
        rd = 5'd0;
        if (ref_taken(f3, a, b))
          nxt = m_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      end
      IMMED:  res = ref_alu(f3, f3 == 3'd5 && insn[30], a, iimm);
      REGREG: res = ref_alu(f3, insn[30], a, b);
      SYSTEM: begin
        src = f3[2] ? {27'b0, rs1} : a;
        if (insn[31:20] == CSR_MSCRATCH) begin
          res = m_mscratch;
          if (f3[1:0] == 2'd1)
            m_mscratch = src;
          else if (f3[1:0] == 2'd2)
            m_mscratch = m_mscratch | src;
          else
            m_mscratch = m_mscratch & ~src;
        end else if (insn[31:20] == CSR_MINSTRET) begin
          res = m_minstret;
        end
      end
      // FENCE retires as a no-op
      default: rd = 5'd0;
    endcase
    if (rd != 5'd0)
      m_regs[rd] = res;
    m_pc = nxt;
    m_minstret = m_minstret + 32'd1;
  endfunction

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input word_t wdata,
                            output word_t rdata, output logic err);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!pready && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!pready)
      abort_run("pready stayed low in the access phase");
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_val(input string what, input word_t exp, input word_t act);
    checks++;
    assert (act === exp)
    else begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic read_checked(input logic [7:0] addr, output word_t data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_val($sformatf("pslverr on read of %h", addr), 32'd0, {31'b0, err});
  endtask

  task automatic check_state(input logic halted, input logic [2:0] cause);
    word_t data;
    read_checked(8'h04, data);
    check_val("PC", m_pc, data);
    read_checked(8'h08, data);
    check_val("STATUS", {28'b0, cause, halted}, data);
    for (int i = 0; i < 32; i++) begin
      read_checked(8'h80 + 8'(4 * i), data);
      check_val($sformatf("x%0d", i), m_regs[i], data);
    end
  endtask

  task automatic exec(input word_t insn);
    word_t unused;
    logic  err;
    apb_access(1'b1, 8'h00, insn, unused, err);
    check_val($sformatf("pslverr on %h", insn), 32'd0, {31'b0, err});
    model_exec(insn);
  endtask

  task automatic exec_fault(input word_t insn, input logic [2:0] cause);
    word_t data;
    logic  err;
    apb_access(1'b1, 8'h00, insn, data, err);
    check_val("pslverr on fault", 32'd0, {31'b0, err});
    read_checked(8'h08, data);
    check_val($sformatf("cause of %h", insn), {28'b0, cause, 1'b0}, data);
    read_checked(8'h04, data);
    check_val("PC held", m_pc, data);
  endtask

  task automatic clear_cause();
    word_t data;
    logic  err;
    apb_access(1'b1, 8'h08, 32'hffff_ffff, data, err);
    check_val("pslverr on STATUS write", 32'd0, {31'b0, err});
    read_checked(8'h08, data);
    check_val("STATUS after clear", 32'd0, data);
  endtask

  task automatic bad_access(input logic wr, input logic [7:0] addr);
    word_t data;
    logic  err;
    apb_access(wr, addr, rand_bits(32), data, err);
    check_val($sformatf("pslverr at %h", addr), 32'd1, {31'b0, err});
  endtask

  task automatic load_reg(input logic [4:0] rd, input word_t upper);
    exec(u_type(upper, rd, LUI));
    exec(i_type(rand_bits(12), rd, 3'd0, rd, IMMED));
  endtask

  task automatic open_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic close_test();
    if (errors == test_errors)
      $display("Test %s: ok", test_name);
    else
      $display("Test %s: %0d check(s) failed", test_name, errors - test_errors);
  endtask

  task automatic alu_ops();
    logic [2:0] f3;
    logic [4:0] rd, rs1, rs2;
    logic       alt;
    open_test("alu");
    for (int i = 1; i < 32; i++)
      load_reg(5'(i), rand_bits(20));
    for (int n = 0; n < 60; n++) begin
      f3  = 3'(rand_bits(3));
      alt = rand_bits(1) == 32'd1;
      rd  = rand_reg();
      rs1 = rand_reg();
      rs2 = rand_reg();
      if (n % 2 == 0)
        exec(r_type({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0}, rs2, rs1, f3, rd,
                    REGREG));
      else if (f3 == 3'd1 || f3 == 3'd5)
        exec(i_type({21'b0, alt && f3 == 3'd5, 5'b0, 5'(rand_bits(5))}, rs1, f3, rd,
                    IMMED));
      else
        exec(i_type(rand_bits(12), rs1, f3, rd, IMMED));
    end
    // SLT and SLTU disagree on -1 versus 1
    exec(i_type(32'hfff, 5'd0, 3'd0, 5'd1, IMMED));
    exec(i_type(32'd1, 5'd0, 3'd0, 5'd2, IMMED));
    exec(r_type(7'd0, 5'd2, 5'd1, 3'd2, 5'd3, REGREG));
    exec(r_type(7'd0, 5'd2, 5'd1, 3'd3, 5'd4, REGREG));
    exec(i_type(32'd5, 5'd0, 3'd0, 5'd0, IMMED));
    exec(32'h0ff0_000f);
    check_state(1'b0, CAUSE_NONE);
    close_test();
  endtask

  task automatic jumps_and_branches();
    logic [2:0] kinds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    word_t      data;
    open_test("jump_branch");
    exec(u_type(rand_bits(20), 5'd3, AUIPC));
    exec(u_type(rand_bits(20), 5'd4, LUI));
    exec(j_type(rand_bits(20) << 1, 5'd1));
    exec(i_type(rand_bits(12), 5'd1, 3'd0, 5'd2, JALR));
    // Opposite signs so that signed and unsigned compares differ
    load_reg(5'd10, rand_bits(20) | 32'h8_0000);
    load_reg(5'd11, rand_bits(20) & 32'h7_ffff);
    foreach (kinds[k]) begin
      exec(b_type(rand_bits(12) << 1, 5'd11, 5'd10, kinds[k]));
      exec(b_type(rand_bits(12) << 1, 5'd10, 5'd11, kinds[k]));
      exec(b_type(rand_bits(12) << 1, 5'd10, 5'd10, kinds[k]));
      read_checked(8'h04, data);
      check_val($sformatf("PC after branch type %0d", kinds[k]), m_pc, data);
    end
    check_state(1'b0, CAUSE_NONE);
    close_test();
  endtask

  task automatic csr_access();
    open_test("csr");
    load_reg(5'd6, rand_bits(20));
    exec(csr_insn(CSR_MSCRATCH, 5'd6, 3'd1, 5'd7));
    exec(csr_insn(CSR_MSCRATCH, 5'd10, 3'd2, 5'd8));
    exec(csr_insn(CSR_MSCRATCH, 5'd11, 3'd3, 5'd9));
    exec(csr_insn(CSR_MSCRATCH, 5'd21, 3'd5, 5'd12));
    exec(csr_insn(CSR_MSCRATCH, 5'd10, 3'd6, 5'd13));
    exec(csr_insn(CSR_MSCRATCH, 5'd3, 3'd7, 5'd14));
    exec(csr_insn(CSR_MSCRATCH, 5'd0, 3'd2, 5'd15));
    // minstret is read-only, the swap only returns the count
    exec(csr_insn(CSR_MINSTRET, 5'd6, 3'd1, 5'd16));
    exec(csr_insn(CSR_MINSTRET, 5'd0, 3'd2, 5'd17));
    check_state(1'b0, CAUSE_NONE);
    close_test();
  endtask

  task automatic fault_causes();
    open_test("faults");
    exec_fault(32'h0000_0000, CAUSE_ILLEGAL);
    exec_fault(32'h0000_0073, CAUSE_ECALL);
    clear_cause();
    exec_fault(32'h0010_0073, CAUSE_EBREAK);
    clear_cause();
    exec_fault(b_type(32'd0, 5'd1, 5'd2, 3'd2), CAUSE_ILLEGAL);
    clear_cause();
    exec_fault(i_type(32'd8, 5'd2, 3'd2, 5'd1, LOAD), CAUSE_MEM_UNSUPPORTED);
    exec_fault({7'd0, 5'd1, 5'd2, 3'd2, 5'd0, STORE}, CAUSE_MEM_UNSUPPORTED);
    clear_cause();
    // None of the faults may have counted as retired
    exec(csr_insn(CSR_MINSTRET, 5'd0, 3'd2, 5'd17));
    check_state(1'b0, CAUSE_NONE);
    close_test();
  endtask

  task automatic bus_errors();
    open_test("bus_errors");
    bad_access(1'b1, 8'h04);
    bad_access(1'b1, 8'h84);
    bad_access(1'b1, 8'h0c);
    bad_access(1'b0, 8'h00);
    bad_access(1'b0, 8'h40);
    bad_access(1'b0, 8'h82);
    check_state(1'b0, CAUSE_NONE);
    close_test();
  endtask

  task automatic halt_freeze();
    word_t data;
    logic  err;
    open_test("halt");
    exec(HALT_INSN_A);
    check_state(1'b1, CAUSE_NONE);
    apb_access(1'b1, 8'h00, i_type(32'd1, 5'd1, 3'd0, 5'd1, IMMED), data, err);
    check_val("pslverr on INSTR while halted", 32'd1, {31'b0, err});
    apb_access(1'b1, 8'h00, HALT_INSN_B, data, err);
    check_val("pslverr on halt while halted", 32'd1, {31'b0, err});
    check_state(1'b1, CAUSE_NONE);
    close_test();
  endtask

  initial begin
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    lfsr       = 32'd20;
    checks     = 0;
    errors     = 0;
    m_pc       = RESET_PC;
    m_mscratch = '0;
    m_minstret = '0;
    for (int i = 0; i < 32; i++)
      m_regs[i] = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    open_test("reset");
    check_state(1'b0, CAUSE_NONE);
    close_test();
    alu_ops();
    jumps_and_branches();
    csr_access();
    fault_causes();
    bus_errors();
    halt_freeze();

    $display("Checks: %0d run, %0d failed, %0d assertion failure(s)",
             checks, errors, u_dut.u_sva.fail_count);
    if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
////////////////////////////////////////////////////////////
// Integer ALU with the branch compare on the same operands
// Shifts use only the low 5 bits of b
////////////////////////////////////////////////////////////
`default_nettype none

module alu
  import rv32i_pkg::*;
(
  input  alu_op_t op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   result_o,
  input  branch_t branch_type_i,
  output logic    taken_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: result_o = {31'b0, a_i < b_i};
      default:  result_o = '0;
    endcase
  end

  // Branch condition
  always_comb begin
    case (branch_type_i)
      BEQ:     taken_o = (a_i == b_i);
      BNE:     taken_o = (a_i != b_i);
      BLT:     taken_o = ($signed(a_i) < $signed(b_i));
      BGE:     taken_o = ($signed(a_i) >= $signed(b_i));
      BLTU:    taken_o = (a_i < b_i);
      BGEU:    taken_o = (a_i >= b_i);
      default: taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/apb_exec_top.sv
////////////////////////////////////////////////////////////
// APB slave in front of the execute core, no wait states
// An INSTR write executes on the edge that ends its access
// Bad accesses complete with pslverr and change nothing
////////////////////////////////////////////////////////////
`default_nettype none

module apb_exec_top
  import rv32i_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  logic [7:0] paddr_i,
  input  word_t      pwdata_i,
  output word_t      prdata_o,
  output logic       pready_o,
  output logic       pslverr_o
);

  logic   access;
  logic   hit_instr, hit_pc, hit_status, hit_reg;
  logic   bad_access;
  logic   exec_valid, clr_cause;
  word_t  pc, dbg_data;
  cause_t cause;
  logic   halted;

  assign access = psel_i && penable_i;

  // Register map decode
  assign hit_instr  = (paddr_i == 8'h00);
  assign hit_pc     = (paddr_i == 8'h04);
  assign hit_status = (paddr_i == 8'h08);
  assign hit_reg    = paddr_i[7] && (paddr_i[1:0] == 2'b00);

  assign bad_access = pwrite_i ? !((hit_instr && !halted) || hit_status)
                               : !(hit_pc || hit_status || hit_reg);

  assign exec_valid = access && pwrite_i && hit_instr && !halted;
  assign clr_cause  = access && pwrite_i && hit_status;

  exec_core #(
    .RESET_PC(RESET_PC)
  ) u_core (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .exec_valid_i(exec_valid),
    .instr_i(pwdata_i), .dbg_idx_i(reg_idx_t'(paddr_i[6:2])),
    .dbg_data_o(dbg_data), .pc_o(pc), .cause_o(cause), .halted_o(halted),
    .clr_cause_i(clr_cause)
  );

  always_comb begin
    if (hit_pc)
      prdata_o = pc;
    else if (hit_status)
      prdata_o = {28'b0, cause, halted};
    else if (hit_reg)
      prdata_o = dbg_data;
    else
      prdata_o = '0;
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access && bad_access;

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
////////////////////////////////////////////////////////////
// Purely combinational RV32I decoder
// Unknown opcodes, reserved branch and SYSTEM forms are illegal
// Loads and stores decode but report an unsupported cause
////////////////////////////////////////////////////////////
`default_nettype none

module control_unit
  import rv32i_pkg::*;
(
  input  word_t     instr_i,
  output reg_idx_t  rs1_o,
  output reg_idx_t  rs2_o,
  output reg_idx_t  rd_o,
  output word_t     imm_o,
  output alu_op_t   alu_op_o,
  output a_sel_t    a_sel_o,
  output b_sel_t    b_sel_o,
  output wb_sel_t   wb_sel_o,
  output logic      wen_o,
  output logic      branch_o,
  output branch_t   branch_type_o,
  output logic      jump_o,
  output logic      jalr_o,
  output logic      csr_swap_o,
  output logic      csr_set_o,
  output logic      csr_clr_o,
  output logic      csr_imm_o,
  output csr_addr_t csr_addr_o,
  output cause_t    cause_o,
  output logic      halt_o
);

  opcode_t     opcode;
  funct3_t     funct3;
  sys_funct3_t sys_funct3;
  word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic        known_opcode;
  logic        bad_branch;
  logic        sys_bad;
  logic        ecall, ebreak;

  assign opcode     = opcode_t'(instr_i[6:0]);
  assign funct3     = funct3_t'(instr_i[14:12]);
  assign sys_funct3 = sys_funct3_t'(instr_i[14:12]);

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  // Immediates of every format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    case (opcode)
      STORE:       imm_o = imm_s;
      BRANCH:      imm_o = imm_b;
      LUI, AUIPC:  imm_o = imm_u;
      JAL:         imm_o = imm_j;
      default:     imm_o = imm_i;
    endcase
  end

  // ALU op from opcode, funct3 and bit 30
  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode == IMMED || opcode == REGREG) begin
      case (funct3)
        F3_ADD:  alu_op_o = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
        F3_SLL:  alu_op_o = ALU_SLL;
        F3_SLT:  alu_op_o = ALU_SLT;
        F3_SLTU: alu_op_o = ALU_SLTU;
        F3_XOR:  alu_op_o = ALU_XOR;
        F3_SR:   alu_op_o = instr_i[30] ? ALU_SRA : ALU_SRL;
        F3_OR:   alu_op_o = ALU_OR;
        F3_AND:  alu_op_o = ALU_AND;
        default: alu_op_o = ALU_ADD;
      endcase
    end
  end

  assign a_sel_o = (opcode == AUIPC) ? A_PC : A_RS1;
  assign b_sel_o = (opcode == REGREG || opcode == BRANCH) ? B_RS2 : B_IMM;

  always_comb begin
    case (opcode)
      JAL, JALR: wb_sel_o = WB_LINK;
      LUI:       wb_sel_o = WB_IMM;
      SYSTEM:    wb_sel_o = WB_CSR;
      default:   wb_sel_o = WB_ALU;
    endcase
  end

  always_comb begin
    case (opcode)
      IMMED, REGREG, LUI, AUIPC, JAL, JALR: wen_o = 1'b1;
      SYSTEM:  wen_o = csr_swap_o | csr_set_o | csr_clr_o;
      default: wen_o = 1'b0;
    endcase
  end

  assign branch_o      = (opcode == BRANCH);
  assign branch_type_o = branch_t'(instr_i[14:12]);
  assign jump_o        = (opcode == JAL) || (opcode == JALR);
  assign jalr_o        = (opcode == JALR);
  // funct3 values 2 and 3 are reserved for branches
  assign bad_branch    = branch_o && (instr_i[14:13] == 2'b01);

  // SYSTEM classification
  always_comb begin
    csr_swap_o = 1'b0;
    csr_set_o  = 1'b0;
    csr_clr_o  = 1'b0;
    csr_imm_o  = 1'b0;
    ecall      = 1'b0;
    ebreak     = 1'b0;
    sys_bad    = 1'b0;
    if (opcode == SYSTEM) begin
      case (sys_funct3)
        CSRRW:  csr_swap_o = 1'b1;
        CSRRS:  csr_set_o  = 1'b1;
        CSRRC:  csr_clr_o  = 1'b1;
        CSRRWI: begin
          csr_swap_o = 1'b1;
          csr_imm_o  = 1'b1;
        end
        CSRRSI: begin
          csr_set_o = 1'b1;
          csr_imm_o = 1'b1;
        end
        CSRRCI: begin
          csr_clr_o = 1'b1;
          csr_imm_o = 1'b1;
        end
        SYS_PRIV: begin
          ecall   = (instr_i[31:7] == 25'd0);
          ebreak  = (instr_i[31:20] == 12'd1) && (instr_i[19:7] == 13'd0);
          sys_bad = !ecall && !ebreak;
        end
        default: sys_bad = 1'b1;
      endcase
    end
  end

  assign csr_addr_o = csr_addr_t'(instr_i[31:20]);

  always_comb begin
    case (opcode)
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
      IMMED, REGREG, FENCE, SYSTEM: known_opcode = 1'b1;
      default:                      known_opcode = 1'b0;
    endcase
  end

  always_comb begin
    if (!known_opcode || bad_branch || sys_bad)
      cause_o = CAUSE_ILLEGAL;
    else if (opcode == LOAD || opcode == STORE)
      cause_o = CAUSE_MEM_UNSUPPORTED;
    else if (ecall)
      cause_o = CAUSE_ECALL;
    else if (ebreak)
      cause_o = CAUSE_EBREAK;
    else
      cause_o = CAUSE_NONE;
  end

  assign halt_o = (instr_i == HALT_INSN_A) || (instr_i == HALT_INSN_B);

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
////////////////////////////////////////////////////////////
// mscratch (read/write) and minstret (read-only counter)
// Other addresses read as zero and drop writes
////////////////////////////////////////////////////////////
`default_nettype none

module csr_file
  import rv32i_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      wr_en_i,
  input  logic      retire_i,
  input  csr_addr_t addr_i,
  input  logic      swap_i,
  input  logic      set_i,
  input  logic      clr_i,
  input  word_t     src_i,
  output word_t     rdata_o
);

  word_t mscratch_q;
  word_t minstret_q;
  word_t new_val;
  logic  do_write;

  always_comb begin
    case (addr_i)
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MINSTRET: rdata_o = minstret_q;
      default:      rdata_o = '0;
    endcase
  end

  always_comb begin
    if (swap_i)
      new_val = src_i;
    else if (set_i)
      new_val = rdata_o | src_i;
    else
      new_val = rdata_o & ~src_i;
  end

  // Set and clear with a zero source leave the CSR alone
  assign do_write = wr_en_i && (addr_i == CSR_MSCRATCH) &&
                    (swap_i || ((set_i || clr_i) && src_i != '0));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mscratch_q <= '0;
      minstret_q <= '0;
    end else begin
      if (do_write)
        mscratch_q <= new_val;
      if (retire_i)
        minstret_q <= minstret_q + 32'd1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exec_core.sv
////////////////////////////////////////////////////////////
// Single-cycle execute datapath, one instruction per strobe
// No fetch path, the PC only records the next address
// A faulting instruction changes nothing but the cause
////////////////////////////////////////////////////////////
`default_nettype none

module exec_core
  import rv32i_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     exec_valid_i,
  input  word_t    instr_i,
  input  reg_idx_t dbg_idx_i,
  output word_t    dbg_data_o,
  output word_t    pc_o,
  output cause_t   cause_o,
  output logic     halted_o,
  input  logic     clr_cause_i
);

  reg_idx_t  rs1, rs2, rd;
  word_t     imm;
  alu_op_t   alu_op;
  a_sel_t    a_sel;
  b_sel_t    b_sel;
  wb_sel_t   wb_sel;
  logic      wen, branch, jump, jalr, halt;
  branch_t   branch_type;
  logic      csr_swap, csr_set, csr_clr, csr_imm;
  csr_addr_t csr_addr;
  cause_t    dec_cause;

  word_t  rs1_data, rs2_data, alu_a, alu_b, alu_res, csr_src, csr_old;
  word_t  wb_data, link, next_pc;
  logic   taken, commit, retire;
  word_t  pc_q;
  cause_t cause_q;
  logic   halted_q;

  control_unit u_ctrl (
    .instr_i(instr_i), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
    .alu_op_o(alu_op), .a_sel_o(a_sel), .b_sel_o(b_sel), .wb_sel_o(wb_sel),
    .wen_o(wen), .branch_o(branch), .branch_type_o(branch_type),
    .jump_o(jump), .jalr_o(jalr), .csr_swap_o(csr_swap), .csr_set_o(csr_set),
    .csr_clr_o(csr_clr), .csr_imm_o(csr_imm), .csr_addr_o(csr_addr),
    .cause_o(dec_cause), .halt_o(halt)
  );

  // Only fault-free instructions touch architectural state
  assign commit = exec_valid_i && !halted_q;
  assign retire = commit && (dec_cause == CAUSE_NONE);

  reg_file u_rf (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .wen_i(retire && wen), .rd_i(rd),
    .wdata_i(wb_data), .rs1_i(rs1), .rs2_i(rs2), .dbg_idx_i(dbg_idx_i),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .dbg_data_o(dbg_data_o)
  );

  assign alu_a = (a_sel == A_PC) ? pc_q : rs1_data;
  assign alu_b = (b_sel == B_IMM) ? imm : rs2_data;

  alu u_alu (
    .op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .result_o(alu_res),
    .branch_type_i(branch_type), .taken_o(taken)
  );

  // Immediate CSR forms take the rs1 field as zimm
  assign csr_src = csr_imm ? {27'b0, rs1} : rs1_data;

  csr_file u_csr (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .wr_en_i(retire && (csr_swap || csr_set || csr_clr)), .retire_i(retire),
    .addr_i(csr_addr), .swap_i(csr_swap), .set_i(csr_set), .clr_i(csr_clr),
    .src_i(csr_src), .rdata_o(csr_old)
  );

  assign link = pc_q + 32'd4;

  always_comb begin
    case (wb_sel)
      WB_LINK: wb_data = link;
      WB_IMM:  wb_data = imm;
      WB_CSR:  wb_data = csr_old;
      default: wb_data = alu_res;
    endcase
  end

  always_comb begin
    if (jalr)
      next_pc = alu_res & ~32'd1;
    else if (jump || (branch && taken))
      next_pc = pc_q + imm;
    else
      next_pc = link;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q     <= RESET_PC;
      cause_q  <= CAUSE_NONE;
      halted_q <= 1'b0;
    end else begin
      if (retire)
        pc_q <= next_pc;
      if (commit && dec_cause != CAUSE_NONE)
        cause_q <= dec_cause;
      else if (clr_cause_i)
        cause_q <= CAUSE_NONE;
      // Sticky until reset
      if (retire && halt)
        halted_q <= 1'b1;
    end
  end

  assign pc_o     = pc_q;
  assign cause_o  = cause_q;
  assign halted_o = halted_q;

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
////////////////////////////////////////////////////////////
// 31 general registers, x0 reads as zero
// Two operand read ports and one debug read port
////////////////////////////////////////////////////////////
`default_nettype none

module reg_file
  import rv32i_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     wen_i,
  input  reg_idx_t rd_i,
  input  word_t    wdata_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  input  reg_idx_t dbg_idx_i,
  output word_t    rs1_data_o,
  output word_t    rs2_data_o,
  output word_t    dbg_data_o
);

  word_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];
  assign dbg_data_o = (dbg_idx_i == 5'd0) ? '0 : regs[dbg_idx_i];

endmodule

`default_nettype wire

// File: verilog/rv32i_pkg.sv
////////////////////////////////////////////////////////////
// Shared types and constants for the RV32I execute subsystem
// Only the machine CSRs mscratch and minstret are modelled
// Halt encodings are CSR writes to 0x780 with rd = x0
////////////////////////////////////////////////////////////
`default_nettype none

package rv32i_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  // Major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    FENCE  = 7'b0001111,
    SYSTEM = 7'b1110011
  } opcode_t;

  // funct3 of register-register and register-immediate ops
  typedef enum logic [2:0] {
    F3_ADD  = 3'd0,
    F3_SLL  = 3'd1,
    F3_SLT  = 3'd2,
    F3_SLTU = 3'd3,
    F3_XOR  = 3'd4,
    F3_SR   = 3'd5,
    F3_OR   = 3'd6,
    F3_AND  = 3'd7
  } funct3_t;

  // funct3 of SYSTEM instructions
  typedef enum logic [2:0] {
    SYS_PRIV = 3'd0,
    CSRRW    = 3'd1,
    CSRRS    = 3'd2,
    CSRRC    = 3'd3,
    CSRRWI   = 3'd5,
    CSRRSI   = 3'd6,
    CSRRCI   = 3'd7
  } sys_funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } alu_op_t;

  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } branch_t;

  typedef enum logic [2:0] {
    CAUSE_NONE            = 3'd0,
    CAUSE_ILLEGAL         = 3'd1,
    CAUSE_ECALL           = 3'd2,
    CAUSE_EBREAK          = 3'd3,
    CAUSE_MEM_UNSUPPORTED = 3'd4
  } cause_t;

  // Operand and writeback selects
  typedef enum logic {A_RS1, A_PC} a_sel_t;
  typedef enum logic {B_RS2, B_IMM} b_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_IMM, WB_CSR} wb_sel_t;

  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MINSTRET = 12'hB02;

  // csrrwi x0, 0x780, 1 and csrrw x0, 0x780, x28
  localparam word_t HALT_INSN_A = 32'h7800d073;
  localparam word_t HALT_INSN_B = 32'h780e1073;

endpackage

`default_nettype wire
